/* rtl/ieuPkg.sv */
// Integer execution unit shared definitions
// Widths, opcodes, ALU/immediate encodings and the pipeline structs

package ieuPkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////
  parameter int Xlen     = 32;           // Register width, fixed by RV32
  parameter int RegAddrW = 5;            // x0..x31

  // Major opcodes handled by this unit
  parameter logic [6:0] OpReg = 7'b0110011;   // OP, register-register
  parameter logic [6:0] OpImm = 7'b0010011;   // OP-IMM
  parameter logic [6:0] OpLui = 7'b0110111;   // LUI

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////
  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt,
    aluSltu,
    aluSll,
    aluSrl,
    aluSra,
    aluPassB                             // Operand B straight through, for lui
  } aluOpE;

  typedef enum logic [1:0] {
    iType,                               // Sign-extended imm[11:0]
    iShift,                              // Zero-extended shamt
    uType                                // imm[31:12] with low bits zero
  } immKindE;

  typedef enum logic [1:0] {
    fromReg,                             // Execute operand register
    fromMem,                             // ALU result in Memory
    fromWb                               // Result in Writeback
  } fwdSelE;

  // Per-instruction control, follows the instruction down the pipe
  typedef struct packed {
    logic    valid;                      // Low means bubble
    logic    regWrite;
    aluOpE   aluOp;
    logic    srcBImm;                    // Immediate as operand B
    immKindE immKind;
  } ctrlT;

  // Register-file write / observable retire port
  typedef struct packed {
    logic                valid;
    logic [RegAddrW-1:0] rd;
    logic [Xlen-1:0]     data;
  } wbT;

endpackage

/* rtl/regFile.sv */
// Integer register file
// Two combinational read ports and one write port, x0 hardwired to zero,
// a read of the register being written sees the new value

module regFile (
  input  logic                             clk,
  input  logic                             we,        // Write enable from Writeback
  input  logic [ieuPkg::RegAddrW-1:0]      ra1, ra2,  // Read addresses
  input  logic [ieuPkg::RegAddrW-1:0]      wa,        // Write address
  input  logic [ieuPkg::Xlen-1:0]          wd,        // Write data
  output logic [ieuPkg::Xlen-1:0]          rd1, rd2
);

  logic [ieuPkg::Xlen-1:0] regs [1:31];               // No storage for x0

  // Registers power up cleared
  initial begin
    for (int i = 1; i < 32; i++) regs[i] = '0;
  end

  always_ff @(posedge clk) begin
    if (we && (wa != '0)) regs[wa] <= wd;             // Writes to x0 are dropped
  end

  // Read with write-through
  always_comb begin
    if (ra1 == '0)              rd1 = '0;
    else if (we && (wa == ra1)) rd1 = wd;
    else                        rd1 = regs[ra1];
    if (ra2 == '0)              rd2 = '0;
    else if (we && (wa == ra2)) rd2 = wd;
    else                        rd2 = regs[ra2];
  end

endmodule

/* rtl/immExtend.sv */
// Immediate extension
// Builds the I-type immediate, the shift amount or the U-type immediate

module immExtend (
  input  logic [31:7]              instr,     // Instruction without the opcode
  input  ieuPkg::immKindE          immKind,
  output logic [ieuPkg::Xlen-1:0]  immExt
);

  always_comb begin
    case (immKind)
      ieuPkg::iType:
        immExt = {{20{instr[31]}}, instr[31:20]};   // Sign-extend imm[11:0]
      ieuPkg::iShift:
        immExt = {27'b0, instr[24:20]};             // shamt only, funct7 dropped
      ieuPkg::uType:
        immExt = {instr[31:12], 12'b0};             // Upper immediate
      default:
        immExt = '0;
    endcase
  end

endmodule

/* rtl/alu.sv */
// Integer ALU
// Add/sub, logic ops, signed and unsigned set-less-than, shifts,
// and a pass-through of operand B for lui

module alu (
  input  logic [ieuPkg::Xlen-1:0]  srcA, srcB,
  input  ieuPkg::aluOpE            aluOp,
  output logic [ieuPkg::Xlen-1:0]  result
);

  logic [4:0] shamt;                          // Shift by low 5 bits only
  logic       ltSigned, ltUnsigned;

  assign shamt      = srcB[4:0];
  assign ltSigned   = $signed(srcA) < $signed(srcB);
  assign ltUnsigned = srcA < srcB;

  always_comb begin
    case (aluOp)
      ieuPkg::aluAdd:   result = srcA + srcB;
      ieuPkg::aluSub:   result = srcA - srcB;
      ieuPkg::aluAnd:   result = srcA & srcB;
      ieuPkg::aluOr:    result = srcA | srcB;
      ieuPkg::aluXor:   result = srcA ^ srcB;
      ieuPkg::aluSlt:   result = {31'b0, ltSigned};
      ieuPkg::aluSltu:  result = {31'b0, ltUnsigned};
      ieuPkg::aluSll:   result = srcA << shamt;
      ieuPkg::aluSrl:   result = srcA >> shamt;
      ieuPkg::aluSra:   result = $unsigned($signed(srcA) >>> shamt);  // Fill with sign
      ieuPkg::aluPassB: result = srcB;                                // lui
      default:          result = '0;
    endcase
  end

endmodule

/* rtl/controller.sv */
// Pipeline controller
// Decodes OP, OP-IMM and LUI into a control word, turns anything else into
// a bubble, and carries the control word through Execute, Memory, Writeback

module controller (
  input  logic          clk,
  input  logic          rstN,
  input  logic          instrValid,   // Issue strobe
  input  logic [31:0]   instr,
  output ieuPkg::ctrlT  ctrlE, ctrlM, ctrlW
);

  logic [6:0]    opcode;
  logic [2:0]    funct3;
  logic [6:0]    funct7;
  logic          legal;
  ieuPkg::ctrlT  ctrlD;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // funct3 mapping shared by OP and OP-IMM
  function automatic ieuPkg::aluOpE baseOp(input logic [2:0] f3);
    case (f3)
      3'b000:  baseOp = ieuPkg::aluAdd;
      3'b001:  baseOp = ieuPkg::aluSll;
      3'b010:  baseOp = ieuPkg::aluSlt;
      3'b011:  baseOp = ieuPkg::aluSltu;
      3'b100:  baseOp = ieuPkg::aluXor;
      3'b101:  baseOp = ieuPkg::aluSrl;
      3'b110:  baseOp = ieuPkg::aluOr;
      default: baseOp = ieuPkg::aluAnd;
    endcase
  endfunction

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////
  always_comb begin
    ctrlD          = '0;
    ctrlD.regWrite = 1'b1;                          // Every supported op writes rd
    ctrlD.immKind  = ieuPkg::iType;
    legal          = 1'b1;
    case (opcode)
      ieuPkg::OpReg: begin
        if (funct7 == 7'b0000000) ctrlD.aluOp = baseOp(funct3);
        else if (funct7 == 7'b0100000 && funct3 == 3'b000) ctrlD.aluOp = ieuPkg::aluSub;
        else if (funct7 == 7'b0100000 && funct3 == 3'b101) ctrlD.aluOp = ieuPkg::aluSra;
        else legal = 1'b0;                          // Unknown funct7
      end
      ieuPkg::OpImm: begin
        ctrlD.srcBImm = 1'b1;
        ctrlD.aluOp   = baseOp(funct3);
        if (funct3 == 3'b001) begin                 // slli
          ctrlD.immKind = ieuPkg::iShift;
          legal         = (funct7 == 7'b0000000);
        end else if (funct3 == 3'b101) begin        // srli / srai
          ctrlD.immKind = ieuPkg::iShift;
          if (funct7 == 7'b0100000) ctrlD.aluOp = ieuPkg::aluSra;
          else if (funct7 != 7'b0000000) legal = 1'b0;
        end
      end
      ieuPkg::OpLui: begin
        ctrlD.srcBImm = 1'b1;
        ctrlD.immKind = ieuPkg::uType;
        ctrlD.aluOp   = ieuPkg::aluPassB;
      end
      default: legal = 1'b0;
    endcase
    // Empty slot or bad encoding becomes an all-zero bubble
    if (instrValid && legal) ctrlD.valid = 1'b1;
    else ctrlD = '0;
  end

  ////////////////////////////////////////
  // Control pipeline E -> M -> W
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      ctrlE <= '0;
      ctrlM <= '0;
      ctrlW <= '0;
    end else begin
      ctrlE <= ctrlD;
      ctrlM <= ctrlE;
      ctrlW <= ctrlM;
    end
  end

endmodule

/* rtl/hazardUnit.sv */
// Forwarding unit
// Picks the source of each Execute operand, Memory beats Writeback

module hazardUnit (
  input  logic [ieuPkg::RegAddrW-1:0]  rs1E, rs2E,
  input  logic [ieuPkg::RegAddrW-1:0]  rdM, rdW,
  input  ieuPkg::ctrlT                 ctrlM, ctrlW,
  output ieuPkg::fwdSelE               fwdAE, fwdBE
);

  logic writesM, writesW;              // Later stage will write a real register

  assign writesM = ctrlM.valid && ctrlM.regWrite && (rdM != '0);
  assign writesW = ctrlW.valid && ctrlW.regWrite && (rdW != '0);

  function automatic ieuPkg::fwdSelE pick(input logic [ieuPkg::RegAddrW-1:0] rs);
    if (writesM && (rdM == rs))      pick = ieuPkg::fromMem;   // Youngest producer first
    else if (writesW && (rdW == rs)) pick = ieuPkg::fromWb;
    else                             pick = ieuPkg::fromReg;
  endfunction

  assign fwdAE = pick(rs1E);
  assign fwdBE = pick(rs2E);

endmodule

/* rtl/datapath.sv */
// Integer datapath
// Register file read in Decode, forwarding and ALU in Execute,
// result carried through Memory to the Writeback write port

module datapath (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic [31:0]                  instr,         // Decode-stage instruction
  input  ieuPkg::ctrlT                 ctrlE, ctrlW,
  input  ieuPkg::ctrlT                 ctrlM,
  input  ieuPkg::fwdSelE               fwdAE, fwdBE,  // Operand sources from hazardUnit
  output logic [ieuPkg::RegAddrW-1:0]  rs1E, rs2E, rdM, rdW,
  output ieuPkg::wbT                   wb
);

  // Decode
  logic [ieuPkg::Xlen-1:0]      rd1D, rd2D;
  // Execute
  logic [31:7]                  instrE;           // Register fields and raw immediate bits
  logic [ieuPkg::Xlen-1:0]      rd1E, rd2E;
  logic [ieuPkg::Xlen-1:0]      immExtE;
  logic [ieuPkg::Xlen-1:0]      fwdSrcAE, fwdSrcBE;
  logic [ieuPkg::Xlen-1:0]      srcBE;
  logic [ieuPkg::Xlen-1:0]      aluResultE;
  // Memory / Writeback
  logic [ieuPkg::Xlen-1:0]      aluResultM;
  logic [ieuPkg::Xlen-1:0]      resultW;
  logic                         regWriteW;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////
  regFile regs (
    .clk (clk),
    .we  (regWriteW),
    .ra1 (instr[19:15]),
    .ra2 (instr[24:20]),
    .wa  (rdW),
    .wd  (resultW),
    .rd1 (rd1D),
    .rd2 (rd2D)
  );

  ////////////////////////////////////////
  // Execute
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      instrE <= '0;
      rd1E   <= '0;
      rd2E   <= '0;
    end else begin
      instrE <= instr[31:7];
      rd1E   <= rd1D;
      rd2E   <= rd2D;
    end
  end

  assign rs1E = instrE[19:15];
  assign rs2E = instrE[24:20];

  immExtend ext (.instr(instrE), .immKind(ctrlE.immKind), .immExt(immExtE));

  // Forwarding muxes
  always_comb begin
    case (fwdAE)
      ieuPkg::fromMem: fwdSrcAE = aluResultM;
      ieuPkg::fromWb:  fwdSrcAE = resultW;
      default:         fwdSrcAE = rd1E;
    endcase
    case (fwdBE)
      ieuPkg::fromMem: fwdSrcBE = aluResultM;
      ieuPkg::fromWb:  fwdSrcBE = resultW;
      default:         fwdSrcBE = rd2E;
    endcase
  end

  assign srcBE = ctrlE.srcBImm ? immExtE : fwdSrcBE;   // Immediate forms

  alu aluE (.srcA(fwdSrcAE), .srcB(srcBE), .aluOp(ctrlE.aluOp), .result(aluResultE));

  ////////////////////////////////////////
  // Memory and Writeback
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      aluResultM <= '0;
      rdM        <= '0;
      resultW    <= '0;
      rdW        <= '0;
    end else begin
      if (ctrlE.valid) begin               // Bubbles leave M untouched
        aluResultM <= aluResultE;
        rdM        <= instrE[11:7];
      end
      if (ctrlM.valid) begin               // Same for W
        resultW <= aluResultM;
        rdW     <= rdM;
      end
    end
  end

  assign regWriteW = ctrlW.valid && ctrlW.regWrite;

  // Retire port mirrors the register-file write, rd 0 included
  assign wb.valid = regWriteW;
  assign wb.rd    = rdW;
  assign wb.data  = resultW;

endmodule

/* rtl/ieuTop.sv */
// Integer execution unit top
// Decode, Execute, Memory and Writeback for the RV32I ALU subset

module ieuTop (
  input  logic         clk,
  input  logic         rstN,
  input  logic         instrValid,   // Issue strobe, low gives a bubble
  input  logic [31:0]  instr,
  output ieuPkg::wbT   wb            // Retire / register write port
);

  ieuPkg::ctrlT                ctrlE, ctrlM, ctrlW;
  ieuPkg::fwdSelE              fwdAE, fwdBE;
  logic [ieuPkg::RegAddrW-1:0] rs1E, rs2E, rdM, rdW;

  controller ctrl (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .instr      (instr),
    .ctrlE      (ctrlE),
    .ctrlM      (ctrlM),
    .ctrlW      (ctrlW)
  );

  datapath dp (
    .clk   (clk),
    .rstN  (rstN),
    .instr (instr),
    .ctrlE (ctrlE),
    .ctrlW (ctrlW),
    .ctrlM (ctrlM),
    .fwdAE (fwdAE),
    .fwdBE (fwdBE),
    .rs1E  (rs1E),
    .rs2E  (rs2E),
    .rdM   (rdM),
    .rdW   (rdW),
    .wb    (wb)
  );

  hazardUnit hzd (
    .rs1E  (rs1E),
    .rs2E  (rs2E),
    .rdM   (rdM),
    .rdW   (rdW),
    .ctrlM (ctrlM),
    .ctrlW (ctrlW),
    .fwdAE (fwdAE),
    .fwdBE (fwdBE)
  );

endmodule

/* sim/ieuChecker.sv */
// Scoreboard for the integer execution unit
// Keeps a reference register file in program order, queues the expected
// writebacks and compares each wb pulse against the head of the queue

module ieuChecker (
  input  logic         clk,
  input  logic         rstN,
  input  logic         instrValid,
  input  logic [31:0]  instr,
  input  ieuPkg::wbT   wb,
  output int           errCount,
  output int           pending                      // Writebacks still expected
);

  logic [31:0] model [32] = '{default: '0};         // Reference registers, x0 never written
  ieuPkg::wbT  expQ [$];
  int          issueQ [$];                          // Sample cycle of each queued entry
  int          cycle = 0;
  int          errs = 0;

  assign errCount = errs;
  assign pending  = expQ.size();

  // ISA result of one instruction, bit 32 set when the encoding is legal
  function automatic logic [32:0] refResult(input logic [31:0] ins);
    logic [31:0] a, b, r;
    logic        isReg, alt, ok;
    isReg = (ins[6:0] == 7'h33);
    alt   = (ins[31:25] == 7'h20);                  // sub / sra / srai
    a     = model[ins[19:15]];
    if (ins[6:0] == 7'h37) return {1'b1, ins[31:12], 12'h000};    // lui
    if (ins[6:0] != 7'h13 && !isReg) return 33'd0;                 // Not OP or OP-IMM
    b = isReg ? model[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
    case (ins[14:12])
      3'd0:    r = (isReg && alt) ? a - b : a + b;
      3'd1:    r = a << b[4:0];
      3'd2:    r = {31'd0, $signed(a) < $signed(b)};
      3'd3:    r = {31'd0, a < b};
      3'd4:    r = a ^ b;
      3'd5:    r = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    r = a | b;
      default: r = a & b;
    endcase
    // funct7 rules
    if (isReg) ok = (ins[31:25] == 7'h00) || (alt && (ins[14:12] == 3'd0 || ins[14:12] == 3'd5));
    else if (ins[14:12] == 3'd1) ok = (ins[31:25] == 7'h00);
    else if (ins[14:12] == 3'd5) ok = (ins[31:25] == 7'h00) || alt;
    else ok = 1'b1;
    return {ok, r};
  endfunction

  ////////////////////////////////////////
  // Compare, then take in the new issue
  ////////////////////////////////////////
  always @(posedge clk) begin
    ieuPkg::wbT  want;
    logic [32:0] res;
    int          issued;
    cycle++;
    if (wb.valid) begin
      if (!rstN || expQ.size() == 0) begin
        $display("Unexpected writeback to x%0d at time %0t, no instruction was outstanding",
                 wb.rd, $time);
        errs++;
      end else begin
        want   = expQ.pop_front();
        issued = issueQ.pop_front();
        if (wb.rd != want.rd || wb.data != want.data) begin
          $display("[FAIL] t=%0t writeback x%0d=%h, expected x%0d=%h",
                   $time, wb.rd, wb.data, want.rd, want.data);
          errs++;
        end
        if (cycle - issued != 3) begin                // Fixed pipeline latency
          $display("[FAIL] t=%0t x%0d retired %0d cycles after issue, expected 3",
                   $time, wb.rd, cycle - issued);
          errs++;
        end
      end
    end
    if (rstN && instrValid) begin
      res = refResult(instr);
      if (res[32]) begin                              // Illegal ones are bubbles
        want.valid = 1'b1;
        want.rd    = instr[11:7];
        want.data  = res[31:0];
        expQ.push_back(want);
        issueQ.push_back(cycle);
        if (instr[11:7] != 5'd0) model[instr[11:7]] = res[31:0];   // Retire in program order
      end
    end
  end

endmodule

/* sim/ieuTb.sv */
// Testbench for the integer execution unit
// LCG-driven instruction streams: reset, R-type, I-type/lui, dependent
// chains, bubbles with illegal encodings, and x0 traffic

module ieuTb;

  localparam int ResetCycles = 16;
  localparam int NumTests    = 6;
  localparam int IssueCycles = ResetCycles + 1 + 262 + 200 + 200 + 200 + 100;
  localparam int CycleLimit  = IssueCycles + 3 * NumTests + 64;
  localparam int DrainLimit  = 8;             // Pipeline latency plus slack

  logic        clk;
  logic        rstN;
  logic        instrValid;
  logic [31:0] instr;
  ieuPkg::wbT  wb;
  int          errCount;
  int          pending;
  int          cycles = 0;
  int          testsPassed = 0;
  int          testsFailed = 0;
  int          errMark = 0;                   // Error count at the start of a test
  logic [31:0] lcgState = 32'h21ba;
  logic [4:0]  prev1 = '0, prev2 = '0, prev3 = '0;   // Recent destinations, newest first

  ieuTop dut (.clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr), .wb(wb));

  ieuChecker chk (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .instr      (instr),
    .wb         (wb),
    .errCount   (errCount),
    .pending    (pending)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////
  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState ^ (lcgState >> 15);       // Fold high bits into the weak low ones
  endfunction

  function automatic logic [4:0] anyReg();
    return 5'(nextRand() % 32'd31) + 5'd1;    // x1..x31
  endfunction

  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                       input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'h13};
  endfunction

  function automatic logic [31:0] randR(input logic [4:0] rd, rs1, rs2);
    logic [31:0] r;
    r = nextRand();
    if ((r[2:0] == 3'd0 || r[2:0] == 3'd5) && r[3]) return encR(7'h20, rs2, rs1, r[2:0], rd);
    return encR(7'h00, rs2, rs1, r[2:0], rd);
  endfunction

  function automatic logic [31:0] randI(input logic [4:0] rd, rs1);
    logic [31:0] r;
    r = nextRand();
    if (r[5:3] == 3'd0) return {r[31:12], rd, 7'h37};                      // lui
    if (r[2:0] == 3'd1) return encI({7'h00, r[24:20]}, rs1, 3'd1, rd);     // slli
    if (r[2:0] == 3'd5) return encI({1'b0, r[6], 5'h00, r[24:20]}, rs1, 3'd5, rd);
    return encI(r[31:20], rs1, r[2:0], rd);   // Sign bit random, so half are negative
  endfunction

  function automatic logic [31:0] randIllegal(input logic [4:0] rd, rs1, rs2);
    logic [31:0] r;
    r = nextRand();
    case (r[1:0])
      2'd0:    return encR(7'h01, rs2, rs1, r[4:2], rd);        // M-extension funct7
      2'd1:    return encR(7'h20, rs2, rs1, 3'd7, rd);          // No alternate and
      2'd2:    return encI({7'h20, r[24:20]}, rs1, 3'd1, rd);   // slli with bad funct7
      default: return {r[31:7], 7'h03};                         // Load, unsupported
    endcase
  endfunction

  function automatic logic [4:0] pickSource(input logic [1:0] sel);
    case (sel)
      2'd0:    return prev1;                  // Forward from M
      2'd1:    return prev2;                  // Forward from W
      2'd2:    return prev3;                  // Write-through
      default: return anyReg();
    endcase
  endfunction

  task automatic issue(input logic v, input logic [31:0] ins);
    @(posedge clk);
    #2;
    instrValid = v;
    instr      = ins;
  endtask

  task automatic chain(input logic [31:0] ins);
    issue(1'b1, ins);
    prev3 = prev2;
    prev2 = prev1;
    prev1 = ins[11:7];
  endtask

  // Drain the pipe, then one status line per test
  task automatic endTest(input string name);
    int waited;
    waited = 0;
    issue(1'b0, '0);
    do begin
      @(posedge clk);
      #2;
      waited++;
    end while (pending != 0 && waited < DrainLimit);
    if (errCount == errMark && pending == 0) begin
      testsPassed++;
      $display("Test %s: passed", name);
    end else begin
      testsFailed++;
      $display("Test %s: failed with %0d errors, %0d writebacks missing", name,
               errCount - errMark, pending);
    end
    errMark = errCount;
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin
    logic [31:0] r;
    logic [4:0]  rd, rsA;
    rstN       = 1'b0;
    instrValid = 1'b0;
    instr      = '0;
    repeat (ResetCycles) @(posedge clk);
    #2;
    rstN = 1'b1;
    endTest("reset");                         // Covers the first cycle after reset too

    for (int i = 1; i < 32; i++)              // Preload, lui then addi
      issue(1'b1, (nextRand() & 32'hffff_f000) | {20'd0, 5'(i), 7'h37});
    for (int i = 1; i < 32; i++)
      issue(1'b1, encI(12'(nextRand()), 5'(i), 3'd0, 5'(i)));
    for (int i = 0; i < 200; i++)             // Sources at least 4 issues older than rd
      issue(1'b1, randR(5'(i % 31) + 5'd1,
                        5'((i + 1 + int'(nextRand() % 32'd27)) % 31) + 5'd1,
                        5'((i + 1 + int'(nextRand() % 32'd27)) % 31) + 5'd1));
    endTest("register-register ops");

    for (int i = 0; i < 200; i++) issue(1'b1, randI(anyReg(), anyReg()));
    endTest("immediate ops and lui");

    for (int i = 0; i < 200; i++) begin
      r = nextRand();
      chain(r[2] ? randR(anyReg(), prev1, pickSource(r[1:0])) : randI(anyReg(), prev1));
    end
    endTest("dependent chains");

    for (int i = 0; i < 200; i++) begin
      r = nextRand();
      case (r[2:0])
        3'd0, 3'd1: issue(1'b0, nextRand());  // Bubble with junk on instr
        3'd2, 3'd3: issue(1'b1, randIllegal(anyReg(), prev1, prev2));
        default:    chain(r[5] ? randR(anyReg(), prev1, pickSource(r[4:3]))
                                : randI(anyReg(), pickSource(r[4:3])));
      endcase
    end
    endTest("bubbles and illegal encodings");

    for (int i = 0; i < 100; i++) begin
      r   = nextRand();
      rd  = r[0] ? 5'd0 : anyReg();
      rsA = r[1] ? 5'd0 : prev1;              // prev1 is often x0 itself
      chain(r[3] ? randR(rd, rsA, r[2] ? 5'd0 : pickSource(r[5:4])) : randI(rd, rsA));
    end
    endTest("x0 writes and reads");

    if (pending != 0) begin
      $display("%0d expected writebacks never appeared", pending);
      testsFailed++;
    end
    $display("Tests passed: %0d, failed: %0d", testsPassed, testsFailed);
    if (testsFailed == 0 && errCount == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Run limit from the issue count plus pipeline latency per test
  always @(posedge clk) begin
    cycles++;
    if (cycles > CycleLimit) begin
      $display("Timeout after %0d cycles with %0d writebacks outstanding", cycles, pending);
      $display("RESULT: FAIL");
      $finish;
    end
  end

endmodule

/* vlog.f */
rtl/ieuPkg.sv
rtl/regFile.sv
rtl/immExtend.sv
rtl/alu.sv
rtl/controller.sv
rtl/hazardUnit.sv
rtl/datapath.sv
rtl/ieuTop.sv
sim/ieuChecker.sv
sim/ieuTb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the execution-unit testbench with Verilator, result in sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -f vlog.f --top-module ieuTb -o ieuSim > sim.log 2>&1 \
  && ./obj_dir/ieuSim >> sim.log 2>&1 \
  || echo "Build or simulation did not complete" >> sim.log
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "No result found in sim.log"; exit 1; }
echo "Simulation passed"
